// File: hw/dram_bridge_config.svh
`ifndef DRAM_BRIDGE_CONFIG_SVH
`define DRAM_BRIDGE_CONFIG_SVH

// Byte address width on the controller user interface.
`define DB_ADDR_W 27

// AXI4-Lite slave widths.
`define DB_AXI_ADDR_W 32
`define DB_DATA_W 64
`define DB_STRB_W (`DB_DATA_W / 8)

// One controller beat covers a 16-byte line, two AXI words.
`define DB_APP_DATA_W 128
`define DB_APP_MASK_W (`DB_APP_DATA_W / 8)
`define DB_LANE_BIT 3

// Requests at or above this byte address get SLVERR.
`define DB_ADDR_LIMIT (33'd1 << `DB_ADDR_W)

`endif

// File: hw/dram_bridge_pkg.sv
`default_nettype none

`include "dram_bridge_config.svh"

package dram_bridge_pkg;

  typedef enum logic [2:0] {
    CMD_WRITE = 3'b000,
    CMD_READ  = 3'b001
  } app_cmd_e;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic                  is_write;
    logic [`DB_ADDR_W-1:0] addr;
    logic [`DB_DATA_W-1:0] wdata;
    logic [`DB_STRB_W-1:0] wstrb;
  } word_req_t;

  // Lane is address bit 3, it picks the half of the beat on reads.
  typedef struct packed {
    logic                      is_write;
    logic [`DB_ADDR_W-1:0]     app_addr;
    logic [`DB_APP_DATA_W-1:0] wdf_data;
    logic [`DB_APP_MASK_W-1:0] wdf_mask;
    logic                      lane;
  } app_req_t;

  typedef struct packed {
    logic [`DB_ADDR_W-1:0]     app_addr;
    app_cmd_e                  app_cmd;
    logic                      app_en;
    logic [`DB_APP_DATA_W-1:0] app_wdf_data;
    logic                      app_wdf_end;
    logic [`DB_APP_MASK_W-1:0] app_wdf_mask;
    logic                      app_wdf_wren;
  } app_ui_out_t;

  typedef struct packed {
    logic                      app_rdy;
    logic                      app_wdf_rdy;
    logic [`DB_APP_DATA_W-1:0] app_rd_data;
    logic                      app_rd_data_valid;
    logic                      app_rd_data_end;
  } app_ui_in_t;

  typedef struct packed {
    logic                  is_write;
    logic [`DB_DATA_W-1:0] rdata;
    logic [1:0]            resp;
  } done_t;

endpackage

`default_nettype wire

// File: hw/pipe_reg.sv
`default_nettype none
`timescale 1ns/100ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire           app_ui_clk,
  input  wire           app_ui_rst,
  input  wire payload_t in_data,
  input  wire           in_valid,
  output logic          in_ready,
  output payload_t      out_data,
  output logic          out_valid,
  input  wire           out_ready
);

  // The stage refills in the same cycle it drains, so it runs at full rate.
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge app_ui_clk) begin
    if (!app_ui_rst) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge app_ui_clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

  a_hold_stalled: assert property (@(posedge app_ui_clk) disable iff (!app_ui_rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: hw/axil_slave_port.sv
`default_nettype none
`timescale 1ns/100ps

`include "dram_bridge_config.svh"

module axil_slave_port (
  input  wire                         app_ui_clk,
  input  wire                         app_ui_rst,
  input  wire [`DB_AXI_ADDR_W-1:0]    awaddr,
  input  wire                         awvalid,
  output logic                        awready,
  input  wire [`DB_DATA_W-1:0]        wdata,
  input  wire [`DB_STRB_W-1:0]        wstrb,
  input  wire                         wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  wire                         bready,
  input  wire [`DB_AXI_ADDR_W-1:0]    araddr,
  input  wire                         arvalid,
  output logic                        arready,
  output logic [`DB_DATA_W-1:0]       rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  wire                         rready,
  output dram_bridge_pkg::word_req_t  req,
  output logic                        req_valid,
  input  wire                         req_ready,
  input  wire dram_bridge_pkg::done_t done,
  input  wire                         done_valid,
  output logic                        done_ready
);
  import dram_bridge_pkg::*;

  logic in_flight;
  logic busy;
  logic wr_range_err;
  logic rd_range_err;

  // Only one transaction at a time, from acceptance until its response is taken.
  assign busy = in_flight | bvalid | rvalid;

  assign awready = !busy && awvalid && wvalid;
  assign wready = awready;
  assign arready = !busy && arvalid && !(awvalid && wvalid);
  assign done_ready = in_flight;

  assign wr_range_err = 33'(awaddr) >= `DB_ADDR_LIMIT;
  assign rd_range_err = 33'(araddr) >= `DB_ADDR_LIMIT;

  always_ff @(posedge app_ui_clk) begin
    if (!app_ui_rst) begin
      req_valid <= 1'b0;
      in_flight <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (req_valid && req_ready) begin
        req_valid <= 1'b0;
      end
      // Out of range requests answer locally and never enter the pipeline.
      if (awready) begin
        if (wr_range_err) begin
          bvalid <= 1'b1;
        end else begin
          req_valid <= 1'b1;
          in_flight <= 1'b1;
        end
      end else if (arready) begin
        if (rd_range_err) begin
          rvalid <= 1'b1;
        end else begin
          req_valid <= 1'b1;
          in_flight <= 1'b1;
        end
      end
      if (done_valid && done_ready) begin
        in_flight <= 1'b0;
        bvalid <= done.is_write;
        rvalid <= !done.is_write;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge app_ui_clk) begin
    if (awready) begin
      req.is_write <= 1'b1;
      req.addr <= awaddr[`DB_ADDR_W-1:0];
      req.wdata <= wdata;
      req.wstrb <= wstrb;
      bresp <= RESP_SLVERR;
    end else if (arready) begin
      req.is_write <= 1'b0;
      req.addr <= araddr[`DB_ADDR_W-1:0];
      req.wdata <= '0;
      req.wstrb <= '0;
      rresp <= RESP_SLVERR;
      rdata <= '0;
    end
    if (done_valid && done_ready) begin
      bresp <= done.resp;
      rresp <= done.resp;
      rdata <= done.rdata;
    end
  end

  a_one_response: assert property (@(posedge app_ui_clk) disable iff (!app_ui_rst)
    !(bvalid && rvalid));

endmodule

`default_nettype wire

// File: hw/app_burst_builder.sv
`default_nettype none
`timescale 1ns/100ps

`include "dram_bridge_config.svh"

module app_burst_builder (
  input  wire dram_bridge_pkg::word_req_t req,
  input  wire                             req_valid,
  output logic                            req_ready,
  output dram_bridge_pkg::app_req_t       app_req,
  output logic                            app_valid,
  input  wire                             app_ready
);

  logic lane;

  assign lane = req.addr[`DB_LANE_BIT];

  assign app_valid = req_valid;
  assign req_ready = app_ready;

  always_comb begin
    app_req.is_write = req.is_write;
    app_req.lane = lane;

    // The controller works on whole 16-byte lines.
    app_req.app_addr = {req.addr[`DB_ADDR_W-1:`DB_LANE_BIT+1], {(`DB_LANE_BIT+1){1'b0}}};

    // Same word in both halves, the mask decides which half lands.
    app_req.wdf_data = {req.wdata, req.wdata};

    // A set mask bit keeps the byte, so only strobed bytes of our lane are open.
    app_req.wdf_mask = '1;
    app_req.wdf_mask[lane*`DB_STRB_W +: `DB_STRB_W] = ~req.wstrb;
  end

endmodule

`default_nettype wire

// File: hw/app_cmd_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

`include "dram_bridge_config.svh"

module app_cmd_sequencer (
  input  wire                              app_ui_clk,
  input  wire                              app_ui_rst,
  input  wire                              calib_complete,
  input  wire dram_bridge_pkg::app_req_t   app_req,
  input  wire                              app_valid,
  output logic                             app_ready,
  output dram_bridge_pkg::app_ui_out_t     app_out,
  input  wire dram_bridge_pkg::app_ui_in_t app_in,
  output logic [`DB_APP_DATA_W-1:0]        rd_beat,
  output logic                             rd_lane,
  output logic                             rd_valid,
  output logic                             wr_done_valid,
  input  wire                              done_ready
);
  import dram_bridge_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DATA,
    ST_CMD,
    ST_RD_WAIT,
    ST_WR_DONE
  } seq_state_e;

  seq_state_e state;
  seq_state_e state_nxt;
  app_req_t   op;

  // Nothing goes to the controller until calibration is done.
  assign app_ready = (state == ST_IDLE) && calib_complete;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (app_valid && app_ready) begin
          state_nxt = app_req.is_write ? ST_DATA : ST_CMD;
        end
      end
      ST_DATA: begin
        if (app_in.app_wdf_rdy) begin
          state_nxt = ST_CMD;
        end
      end
      ST_CMD: begin
        if (app_in.app_rdy) begin
          state_nxt = op.is_write ? ST_WR_DONE : ST_RD_WAIT;
        end
      end
      ST_RD_WAIT: begin
        if (rd_valid) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_WR_DONE: begin
        if (done_ready) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge app_ui_clk) begin
    if (!app_ui_rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge app_ui_clk) begin
    if (app_valid && app_ready) begin
      op <= app_req;
    end
  end

  always_comb begin
    app_out.app_addr = op.app_addr;
    app_out.app_cmd = op.is_write ? CMD_WRITE : CMD_READ;
    app_out.app_en = (state == ST_CMD);
    app_out.app_wdf_data = op.wdf_data;
    app_out.app_wdf_mask = op.wdf_mask;
    // Single beat burst, so end goes with every write enable.
    app_out.app_wdf_wren = (state == ST_DATA);
    app_out.app_wdf_end = (state == ST_DATA);
  end

  assign rd_beat = app_in.app_rd_data;
  assign rd_lane = op.lane;
  assign rd_valid = (state == ST_RD_WAIT) && app_in.app_rd_data_valid && app_in.app_rd_data_end;
  assign wr_done_valid = (state == ST_WR_DONE);

  a_wren_write_only: assert property (@(posedge app_ui_clk) disable iff (!app_ui_rst)
    app_out.app_wdf_wren |-> op.is_write);

  a_cmd_held: assert property (@(posedge app_ui_clk) disable iff (!app_ui_rst)
    app_out.app_en && !app_in.app_rdy |=>
      app_out.app_en && $stable(app_out.app_addr) && $stable(app_out.app_cmd));

endmodule

`default_nettype wire

// File: hw/read_lane_select.sv
`default_nettype none
`timescale 1ns/100ps

`include "dram_bridge_config.svh"

module read_lane_select (
  input  wire                        app_ui_clk,
  input  wire                        app_ui_rst,
  input  wire [`DB_APP_DATA_W-1:0]   rd_beat,
  input  wire                        rd_lane,
  input  wire                        rd_valid,
  input  wire                        wr_done_valid,
  output dram_bridge_pkg::done_t     done,
  output logic                       done_valid,
  input  wire                        done_ready
);
  import dram_bridge_pkg::*;

  logic wr_take;

  assign wr_take = wr_done_valid && done_ready;

  always_ff @(posedge app_ui_clk) begin
    if (!app_ui_rst) begin
      done_valid <= 1'b0;
    end else if (rd_valid || wr_take) begin
      done_valid <= 1'b1;
    end else if (done_ready) begin
      done_valid <= 1'b0;
    end
  end

  always_ff @(posedge app_ui_clk) begin
    if (rd_valid) begin
      done.is_write <= 1'b0;
      done.rdata <= rd_lane ? rd_beat[`DB_APP_DATA_W-1:`DB_DATA_W] : rd_beat[`DB_DATA_W-1:0];
      done.resp <= RESP_OKAY;
    end else if (wr_take) begin
      done.is_write <= 1'b1;
      done.rdata <= '0;
      done.resp <= RESP_OKAY;
    end
  end

  // Read data cannot be stalled, the AXI side must already be waiting for it.
  a_rd_slot_free: assert property (@(posedge app_ui_clk) disable iff (!app_ui_rst)
    rd_valid |-> !done_valid || done_ready);

endmodule

`default_nettype wire

// File: hw/dram_bridge_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "dram_bridge_config.svh"

module dram_bridge_top (
  input  wire                              app_ui_clk,
  input  wire                              app_ui_rst,
  input  wire [`DB_AXI_ADDR_W-1:0]         awaddr,
  input  wire                              awvalid,
  output logic                             awready,
  input  wire [`DB_DATA_W-1:0]             wdata,
  input  wire [`DB_STRB_W-1:0]             wstrb,
  input  wire                              wvalid,
  output logic                             wready,
  output logic [1:0]                       bresp,
  output logic                             bvalid,
  input  wire                              bready,
  input  wire [`DB_AXI_ADDR_W-1:0]         araddr,
  input  wire                              arvalid,
  output logic                             arready,
  output logic [`DB_DATA_W-1:0]            rdata,
  output logic [1:0]                       rresp,
  output logic                             rvalid,
  input  wire                              rready,
  input  wire                              calib_complete,
  output dram_bridge_pkg::app_ui_out_t     app_out,
  input  wire dram_bridge_pkg::app_ui_in_t app_in
);
  import dram_bridge_pkg::*;

  word_req_t                 port_req;
  logic                      port_req_valid;
  logic                      port_req_ready;
  word_req_t                 word_q;
  logic                      word_q_valid;
  logic                      word_q_ready;
  app_req_t                  burst;
  logic                      burst_valid;
  logic                      burst_ready;
  app_req_t                  burst_q;
  logic                      burst_q_valid;
  logic                      burst_q_ready;
  logic [`DB_APP_DATA_W-1:0] rd_beat;
  logic                      rd_lane;
  logic                      rd_valid;
  logic                      wr_done_valid;
  done_t                     done;
  logic                      done_valid;
  logic                      done_ready;

  axil_slave_port u_port (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .req        (port_req),
    .req_valid  (port_req_valid),
    .req_ready  (port_req_ready),
    .done       (done),
    .done_valid (done_valid),
    .done_ready (done_ready)
  );

  pipe_reg #(.payload_t(word_req_t)) u_word_reg (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .in_data    (port_req),
    .in_valid   (port_req_valid),
    .in_ready   (port_req_ready),
    .out_data   (word_q),
    .out_valid  (word_q_valid),
    .out_ready  (word_q_ready)
  );

  app_burst_builder u_builder (
    .req       (word_q),
    .req_valid (word_q_valid),
    .req_ready (word_q_ready),
    .app_req   (burst),
    .app_valid (burst_valid),
    .app_ready (burst_ready)
  );

  pipe_reg #(.payload_t(app_req_t)) u_burst_reg (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .in_data    (burst),
    .in_valid   (burst_valid),
    .in_ready   (burst_ready),
    .out_data   (burst_q),
    .out_valid  (burst_q_valid),
    .out_ready  (burst_q_ready)
  );

  app_cmd_sequencer u_seq (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .calib_complete (calib_complete),
    .app_req        (burst_q),
    .app_valid      (burst_q_valid),
    .app_ready      (burst_q_ready),
    .app_out        (app_out),
    .app_in         (app_in),
    .rd_beat        (rd_beat),
    .rd_lane        (rd_lane),
    .rd_valid       (rd_valid),
    .wr_done_valid  (wr_done_valid),
    .done_ready     (done_ready)
  );

  read_lane_select u_lane (
    .app_ui_clk    (app_ui_clk),
    .app_ui_rst    (app_ui_rst),
    .rd_beat       (rd_beat),
    .rd_lane       (rd_lane),
    .rd_valid      (rd_valid),
    .wr_done_valid (wr_done_valid),
    .done          (done),
    .done_valid    (done_valid),
    .done_ready    (done_ready)
  );

endmodule

`default_nettype wire

// File: sim/app_ui_model.sv
`default_nettype none
`timescale 1ns/100ps

`include "dram_bridge_config.svh"

module app_ui_model #(
  parameter int unsigned SEED = 1,
  parameter int unsigned CALIB_CYCLES = 20
) (
  input  wire                               app_ui_clk,
  input  wire                               app_ui_rst,
  input  wire dram_bridge_pkg::app_ui_out_t app_out,
  output dram_bridge_pkg::app_ui_in_t       app_in,
  output logic                              calib_complete,
  output int unsigned                       cmd_count,
  output logic                              proto_err
);
  import dram_bridge_pkg::*;

  localparam int LINE_W = `DB_ADDR_W - 4;

  logic [`DB_APP_DATA_W-1:0] mem [logic [LINE_W-1:0]];
  logic [`DB_APP_DATA_W-1:0] wdf_data_q [$];
  logic [`DB_APP_MASK_W-1:0] wdf_mask_q [$];
  logic [`DB_APP_DATA_W-1:0] rd_data_q [$];
  int unsigned               rd_due_q [$];
  int unsigned               cycle_cnt;

  // Bytes never written read back as a pattern of their own address.
  function automatic logic [7:0] fill_byte(input logic [`DB_ADDR_W-1:0] addr);
    return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {5'b0, addr[`DB_ADDR_W-1:24]} ^ 8'h5a;
  endfunction

  function automatic logic [`DB_APP_DATA_W-1:0] read_line(input logic [LINE_W-1:0] line);
    logic [`DB_APP_DATA_W-1:0] beat;
    if (mem.exists(line)) begin
      beat = mem[line];
    end else begin
      for (int i = 0; i < `DB_APP_MASK_W; i++) begin
        beat[i*8 +: 8] = fill_byte({line, 4'(i)});
      end
    end
    return beat;
  endfunction

  task automatic take_requests();
    logic [`DB_APP_DATA_W-1:0] beat;
    logic [`DB_APP_DATA_W-1:0] data;
    logic [`DB_APP_MASK_W-1:0] mask;
    logic [LINE_W-1:0]         line;
    if ((app_out.app_en || app_out.app_wdf_wren) && !calib_complete) begin
      proto_err = 1'b1;
    end
    if (app_out.app_wdf_wren && app_in.app_wdf_rdy) begin
      if (!app_out.app_wdf_end) begin
        proto_err = 1'b1;
      end
      wdf_data_q.push_back(app_out.app_wdf_data);
      wdf_mask_q.push_back(app_out.app_wdf_mask);
    end
    if (app_out.app_en && app_in.app_rdy) begin
      cmd_count++;
      if (app_out.app_addr[3:0] != 4'h0) begin
        proto_err = 1'b1;
      end
      line = app_out.app_addr[`DB_ADDR_W-1:4];
      beat = read_line(line);
      if (app_out.app_cmd == CMD_WRITE) begin
        if (wdf_data_q.size() == 0) begin
          proto_err = 1'b1;
        end else begin
          data = wdf_data_q.pop_front();
          mask = wdf_mask_q.pop_front();
          // A set mask bit leaves the byte as it was.
          for (int i = 0; i < `DB_APP_MASK_W; i++) begin
            if (!mask[i]) begin
              beat[i*8 +: 8] = data[i*8 +: 8];
            end
          end
          mem[line] = beat;
        end
      end else begin
        rd_data_q.push_back(beat);
        rd_due_q.push_back(cycle_cnt + 3 + ($urandom % 8));
      end
    end
  endtask

  task automatic drive_outputs();
    calib_complete = (cycle_cnt >= CALIB_CYCLES);
    if (!app_ui_rst) begin
      app_in.app_rdy = 1'b0;
      app_in.app_wdf_rdy = 1'b0;
    end else begin
      app_in.app_rdy = ($urandom % 4) != 0;
      app_in.app_wdf_rdy = ($urandom % 4) != 0;
    end
    app_in.app_rd_data_valid = 1'b0;
    app_in.app_rd_data_end = 1'b0;
    if (rd_due_q.size() != 0 && cycle_cnt >= rd_due_q[0]) begin
      void'(rd_due_q.pop_front());
      app_in.app_rd_data = rd_data_q.pop_front();
      app_in.app_rd_data_valid = 1'b1;
      app_in.app_rd_data_end = 1'b1;
    end
  endtask

  // Requests are taken on the rising edge, responses change on the falling edge.
  initial begin
    void'($urandom(SEED));
    cycle_cnt = 0;
    cmd_count = 0;
    proto_err = 1'b0;
    calib_complete = 1'b0;
    app_in = '0;
    forever begin
      @(posedge app_ui_clk);
      if (app_ui_rst) begin
        take_requests();
      end
      cycle_cnt++;
      @(negedge app_ui_clk);
      drive_outputs();
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_dram_bridge.sv
`default_nettype none
`timescale 1ns/100ps

`include "dram_bridge_config.svh"

module tb_dram_bridge;
  import dram_bridge_pkg::*;

  localparam int unsigned SEED = 68602;
  localparam int RANDOM_OPS = 50;
  localparam int TXN_COUNT = 16 + RANDOM_OPS;
  localparam int CYCLES_PER_TXN = 200;
  localparam logic [31:0] OUT_OF_RANGE_ADDR = 32'h0800_0000;

  logic                        app_ui_clk;
  logic                        app_ui_rst;
  logic [`DB_AXI_ADDR_W-1:0]   awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [`DB_DATA_W-1:0]       wdata;
  logic [`DB_STRB_W-1:0]       wstrb;
  logic                        wvalid;
  logic                        wready;
  logic [1:0]                  bresp;
  logic                        bvalid;
  logic                        bready;
  logic [`DB_AXI_ADDR_W-1:0]   araddr;
  logic                        arvalid;
  logic                        arready;
  logic [`DB_DATA_W-1:0]       rdata;
  logic [1:0]                  rresp;
  logic                        rvalid;
  logic                        rready;
  logic                        calib_complete;
  app_ui_out_t                 app_out;
  app_ui_in_t                  app_in;
  int unsigned                 cmd_count;
  logic                        proto_err;

  logic [7:0]            sb_mem [logic [`DB_ADDR_W-1:0]];
  logic                  exp_write_q [$];
  logic [`DB_DATA_W-1:0] exp_data_q [$];

  dram_bridge_top DUT (.*);

  app_ui_model #(.SEED(SEED), .CALIB_CYCLES(20)) u_model (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .app_out        (app_out),
    .app_in         (app_in),
    .calib_complete (calib_complete),
    .cmd_count      (cmd_count),
    .proto_err      (proto_err)
  );

  initial begin
    app_ui_clk = 1'b0;
    forever #50 app_ui_clk = ~app_ui_clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else report_failure(what);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else
      report_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Same fill rule as the controller model uses for bytes never written.
  function automatic logic [7:0] fill_byte(input logic [`DB_ADDR_W-1:0] addr);
    return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {5'b0, addr[`DB_ADDR_W-1:24]} ^ 8'h5a;
  endfunction

  function automatic logic [`DB_DATA_W-1:0] expected_word(input logic [31:0] addr);
    logic [`DB_ADDR_W-1:0] a;
    logic [`DB_DATA_W-1:0] word;
    for (int i = 0; i < 8; i++) begin
      a = {addr[`DB_ADDR_W-1:3], 3'(i)};
      if (sb_mem.exists(a)) begin
        word[i*8 +: 8] = sb_mem[a];
      end else begin
        word[i*8 +: 8] = fill_byte(a);
      end
    end
    return word;
  endfunction

  task automatic update_scoreboard(input logic [31:0] addr, input logic [63:0] data,
                                   input logic [7:0] strb);
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        sb_mem[{addr[`DB_ADDR_W-1:3], 3'(i)}] = data[i*8 +: 8];
      end
    end
  endtask

  // Bus tasks start and end just after a falling edge.
  task automatic send_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    do begin
      @(posedge app_ui_clk);
    end while (!(awready && wready));
    @(negedge app_ui_clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
  endtask

  task automatic send_read(input logic [31:0] addr);
    araddr = addr;
    arvalid = 1'b1;
    do begin
      @(posedge app_ui_clk);
    end while (!arready);
    @(negedge app_ui_clk);
    arvalid = 1'b0;
  endtask

  task automatic get_write_resp(output logic [1:0] resp, output int cycles);
    cycles = 0;
    bready = 1'b1;
    do begin
      @(posedge app_ui_clk);
      cycles++;
    end while (!bvalid);
    resp = bresp;
    @(negedge app_ui_clk);
    bready = 1'b0;
  endtask

  task automatic get_read_resp(output logic [1:0] resp, output logic [63:0] data,
                               output int cycles);
    cycles = 0;
    rready = 1'b1;
    do begin
      @(posedge app_ui_clk);
      cycles++;
    end while (!rvalid);
    resp = rresp;
    data = rdata;
    @(negedge app_ui_clk);
    rready = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    logic [1:0] resp;
    int         cycles;
    send_write(addr, data, strb);
    get_write_resp(resp, cycles);
    check_value("bresp", resp, RESP_OKAY);
    update_scoreboard(addr, data, strb);
  endtask

  task automatic read_word(input logic [31:0] addr);
    logic [1:0]  resp;
    logic [63:0] data;
    int          cycles;
    send_read(addr);
    get_read_resp(resp, data, cycles);
    check_value("rresp", resp, RESP_OKAY);
    check_value("rdata", data, expected_word(addr));
  endtask

  task automatic test_reset_state();
    check_true(!awready && !wready && !arready, "An AXI ready was high after reset.");
    check_true(!bvalid && !rvalid, "A response was pending after reset.");
    check_true(!app_out.app_en && !app_out.app_wdf_wren,
               "The controller interface was active after reset.");
  endtask

  task automatic test_write_before_calib();
    logic [1:0] resp;
    int         cycles;
    send_write(32'h0000_0100, 64'h0123_4567_89ab_cdef, 8'hff);
    bready = 1'b1;
    @(posedge app_ui_clk);
    check_true(!calib_complete, "The write was only accepted after calibration.");
    while (!calib_complete) begin
      @(posedge app_ui_clk);
      check_true(!bvalid, "The write completed before calibration.");
      check_true(cmd_count == 0, "A command reached the controller before calibration.");
    end
    @(negedge app_ui_clk);
    get_write_resp(resp, cycles);
    check_value("bresp", resp, RESP_OKAY);
    update_scoreboard(32'h0000_0100, 64'h0123_4567_89ab_cdef, 8'hff);
    read_word(32'h0000_0100);
  endtask

  task automatic test_both_lanes();
    write_word(32'h0000_2000, 64'h1111_2222_3333_4444, 8'hff);
    write_word(32'h0000_2008, 64'h5555_6666_7777_8888, 8'hff);
    read_word(32'h0000_2000);
    read_word(32'h0000_2008);
  endtask

  task automatic test_partial_strobe();
    write_word(32'h0000_3000, 64'haaaa_aaaa_aaaa_aaaa, 8'hff);
    write_word(32'h0000_3008, 64'hbbbb_bbbb_bbbb_bbbb, 8'hff);
    write_word(32'h0000_3008, 64'hc0c1_c2c3_c4c5_c6c7, 8'h5a);
    read_word(32'h0000_3008);
    read_word(32'h0000_3000);
  endtask

  task automatic test_out_of_range();
    int unsigned cmds;
    logic [1:0]  resp;
    logic [63:0] data;
    int          cycles;
    cmds = cmd_count;
    send_write(OUT_OF_RANGE_ADDR, 64'hdead_beef_dead_beef, 8'hff);
    get_write_resp(resp, cycles);
    check_value("bresp", resp, RESP_SLVERR);
    check_value("bvalid latency", cycles, 1);
    send_read(32'hffff_fff8);
    get_read_resp(resp, data, cycles);
    check_value("rresp", resp, RESP_SLVERR);
    check_value("rvalid latency", cycles, 1);
    repeat (10) @(negedge app_ui_clk);
    check_true(cmd_count == cmds, "An out of range request reached the controller.");
    // The write above aliases line 0 if the upper address bits were dropped.
    read_word(32'h0000_0000);
  endtask

  task automatic issue_random_ops();
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  strb;
    logic        is_write;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      is_write = 1'($urandom % 2);
      addr = 32'h0000_4000 | 32'(($urandom % 32) << 3);
      data = {$urandom, $urandom};
      strb = 8'($urandom);
      exp_write_q.push_back(is_write);
      if (is_write) begin
        update_scoreboard(addr, data, strb);
        exp_data_q.push_back('0);
        send_write(addr, data, strb);
      end else begin
        exp_data_q.push_back(expected_word(addr));
        send_read(addr);
      end
    end
  endtask

  task automatic drain_responses();
    int unsigned stall;
    logic        exp_write;
    logic [63:0] exp_data;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      stall = $urandom % 8;
      repeat (stall) begin
        @(posedge app_ui_clk);
        if (bvalid || rvalid) begin
          check_true(!awready && !arready, "A request was accepted while a response was held.");
        end
        @(negedge app_ui_clk);
      end
      bready = 1'b1;
      rready = 1'b1;
      do begin
        @(posedge app_ui_clk);
      end while (!(bvalid || rvalid));
      check_true(exp_write_q.size() != 0, "A response arrived with no request outstanding.");
      exp_write = exp_write_q.pop_front();
      exp_data = exp_data_q.pop_front();
      if (exp_write) begin
        check_true(bvalid, "A read response came where a write response was expected.");
        check_value("bresp", bresp, RESP_OKAY);
      end else begin
        check_true(rvalid, "A write response came where a read response was expected.");
        check_value("rresp", rresp, RESP_OKAY);
        check_value("rdata", rdata, exp_data);
      end
      @(negedge app_ui_clk);
      bready = 1'b0;
      rready = 1'b0;
    end
  endtask

  task automatic test_random_backpressure();
    int unsigned cmds;
    cmds = cmd_count;
    fork
      issue_random_ops();
      drain_responses();
    join
    // Every in-range request gives exactly one controller command.
    check_value("cmd_count", cmd_count - cmds, RANDOM_OPS);
  endtask

  initial begin : watchdog
    repeat (TXN_COUNT * CYCLES_PER_TXN) @(posedge app_ui_clk);
    report_failure("Timeout, the tests did not finish in the expected number of cycles.");
  end

  initial begin : main
    void'($urandom(SEED));
    app_ui_rst = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (2) @(posedge app_ui_clk);
    @(negedge app_ui_clk);
    app_ui_rst = 1'b1;
    test_reset_state();
    test_write_before_calib();
    test_both_lanes();
    test_partial_strobe();
    test_out_of_range();
    test_random_backpressure();
    check_true(!proto_err, "The controller model saw a protocol violation.");
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/dram_bridge_pkg.sv
hw/pipe_reg.sv
hw/axil_slave_port.sv
hw/app_burst_builder.sv
hw/app_cmd_sequencer.sv
hw/read_lane_select.sv
hw/dram_bridge_top.sv
sim/app_ui_model.sv
sim/tb_dram_bridge.sv

// File: Bender.yml
package:
  name: dram_bridge

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dram_bridge_pkg.sv
      - hw/pipe_reg.sv
      - hw/axil_slave_port.sv
      - hw/app_burst_builder.sv
      - hw/app_cmd_sequencer.sv
      - hw/read_lane_select.sv
      - hw/dram_bridge_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/app_ui_model.sv
      - sim/tb_dram_bridge.sv
